// ==== pwr_cfg_pkg.sv ====
/*
 * Power harness configuration
 * Sizes of the gated domains and the switch-cell acknowledge latency
 */
package pwr_cfg_pkg;

  // External power domains driven by the sequencers
  localparam int unsigned NUM_DOMAINS = 4;

  // Width of a domain index in a command
  localparam int unsigned DOMAIN_IDX_W = (NUM_DOMAINS > 1) ? $clog2(NUM_DOMAINS) : 1;

  // Memory banks with their own switch bits
  localparam int unsigned NUM_BANKS = 2;

  // Cycles from a switch change to the matching acknowledge
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

endpackage

// ==== pwr_types_pkg.sv ====
/*
 * Power harness types
 * Command, control and status records plus the domain sequencer states
 */
package pwr_types_pkg;

  import pwr_cfg_pkg::*;

  // Single-cycle power command for one domain
  typedef struct packed {
    logic                    valid;
    logic [DOMAIN_IDX_W-1:0] domain;
    logic                    off;     // 1 requests power off
  } pwr_cmd_t;

  // Active-low controls of one gated domain
  typedef struct packed {
    logic switch_n;
    logic iso_n;
    logic rst_n;
  } domain_ctrl_t;

  // Off path runs ON to OFF, on path runs OFF back to ON
  typedef enum logic [2:0] {
    ON,
    ISO,
    RST,
    SW_OFF,
    OFF,
    SW_ON,
    UNRST,
    UNISO
  } domain_state_e;

  // Per-domain status towards the collector
  typedef struct packed {
    logic powered;
    logic done;
  } domain_stat_t;

  typedef logic [NUM_BANKS-1:0] bank_mask_t;

endpackage

// ==== switch_ack_delay.sv ====
/*
 * Power switch cell model
 * Returns the switch control as its acknowledge after a fixed latency
 */
`timescale 1ns/1ps

module switch_ack_delay
  import pwr_cfg_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t switch_n_i,
  output payload_t ack_n_o
);

  // One stage per cycle of switch latency
  payload_t chain_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Switch closed and acknowledged out of reset
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        chain_q[i] <= '0;
      end
    end else begin
      chain_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  assign ack_n_o = chain_q[SWITCH_ACK_LATENCY-1];

endmodule

// ==== pwr_cmd_decoder.sv ====
/*
 * Power command decoder
 * Keeps the requested power state of every domain from command strobes
 */
`timescale 1ns/1ps

module pwr_cmd_decoder
  import pwr_cfg_pkg::*;
  import pwr_types_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  pwr_cmd_t               cmd_i,
  output logic [NUM_DOMAINS-1:0] target_off_o
);

  logic [NUM_DOMAINS-1:0] target_off_q;
  logic                   cmd_hit;

  // Drop strobes that name a domain which does not exist
  assign cmd_hit = cmd_i.valid && (int'(cmd_i.domain) < NUM_DOMAINS);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // All domains requested on
      target_off_q <= '0;
    end else if (cmd_hit) begin
      target_off_q[cmd_i.domain] <= cmd_i.off;
    end
  end

  assign target_off_o = target_off_q;

endmodule

// ==== pwr_domain_seq.sv ====
/*
 * Domain power sequencer
 * Orders isolation, reset and switch of one domain on power-off and power-on
 */
`timescale 1ns/1ps

module pwr_domain_seq
  import pwr_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         target_off_i,
  input  logic         switch_ack_n_i,
  output domain_ctrl_t ctrl_o,
  output domain_stat_t stat_o
);

  domain_state_e state_q;
  domain_state_e state_d;
  logic          done_q;
  logic          settle;

  // Entering one of the two stable states
  assign settle = (state_d != state_q) && ((state_d == ON) || (state_d == OFF));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ON: begin
        // Target only checked while stable
        if (target_off_i) begin
          state_d = ISO;
        end
      end
      ISO: begin
        state_d = RST;
      end
      RST: begin
        state_d = SW_OFF;
      end
      SW_OFF: begin
        if (switch_ack_n_i) begin
          state_d = OFF;
        end
      end
      OFF: begin
        if (!target_off_i) begin
          state_d = SW_ON;
        end
      end
      SW_ON: begin
        // Wait for the supply to come back
        if (!switch_ack_n_i) begin
          state_d = UNRST;
        end
      end
      UNRST: begin
        state_d = UNISO;
      end
      UNISO: begin
        state_d = ON;
      end
      default: begin
        state_d = ON;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ON;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= settle;
    end
  end

  // Controls decoded from the state register
  assign ctrl_o.switch_n = (state_q == SW_OFF) || (state_q == OFF);
  assign ctrl_o.iso_n    = (state_q == ON) || (state_q == UNISO);
  assign ctrl_o.rst_n    = (state_q == ON) || (state_q == ISO) ||
                           (state_q == UNRST) || (state_q == UNISO);

  // Supply present unless the switch is open and acknowledged
  assign stat_o.powered = (state_q != OFF) && (state_q != SW_ON);
  assign stat_o.done    = done_q;

endmodule

// ==== pwr_status_collector.sv ====
/*
 * Power status collector
 * Registers the powered domains and keeps sticky per-domain done interrupts
 */
`timescale 1ns/1ps

module pwr_status_collector
  import pwr_cfg_pkg::*;
  import pwr_types_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  domain_stat_t [NUM_DOMAINS-1:0]     stat_i,
  input  logic         [NUM_DOMAINS-1:0]     intr_clear_i,
  output logic         [NUM_DOMAINS-1:0]     power_on_o,
  output logic         [NUM_DOMAINS-1:0]     intr_o
);

  logic [NUM_DOMAINS-1:0] powered;
  logic [NUM_DOMAINS-1:0] done;
  logic [NUM_DOMAINS-1:0] power_on_q;
  logic [NUM_DOMAINS-1:0] intr_q;

  // Unpack the status records into flat vectors
  always_comb begin
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      powered[i] = stat_i[i].powered;
      done[i]    = stat_i[i].done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      power_on_q <= '1;
      intr_q     <= '0;
    end else begin
      power_on_q <= powered;
      // A new completion beats a clear in the same cycle
      intr_q     <= (intr_q & ~intr_clear_i) | done;
    end
  end

  assign power_on_o = power_on_q;
  assign intr_o     = intr_q;

endmodule

// ==== power_harness_top.sv ====
/*
 * Power gating harness
 * Command decoder, per-domain sequencers with switch models, status collector
 */
`timescale 1ns/1ps

module power_harness_top
  import pwr_cfg_pkg::*;
  import pwr_types_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  pwr_cmd_t                       cmd_i,
  input  logic         [NUM_DOMAINS-1:0] intr_clear_i,
  input  bank_mask_t                     banks_switch_n_i,
  output domain_ctrl_t [NUM_DOMAINS-1:0] domain_ctrl_o,
  output logic         [NUM_DOMAINS-1:0] power_on_o,
  output logic         [NUM_DOMAINS-1:0] intr_o,
  output bank_mask_t                     banks_ack_n_o
);

  logic         [NUM_DOMAINS-1:0] target_off;
  logic         [NUM_DOMAINS-1:0] switch_ack_n;
  domain_stat_t [NUM_DOMAINS-1:0] domain_stat;

  pwr_cmd_decoder i_pwr_cmd_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_i        (cmd_i),
    .target_off_o (target_off)
  );

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_domain
    pwr_domain_seq i_pwr_domain_seq (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .target_off_i   (target_off[d]),
      .switch_ack_n_i (switch_ack_n[d]),
      .ctrl_o         (domain_ctrl_o[d]),
      .stat_o         (domain_stat[d])
    );

    // Switch cell of this domain
    switch_ack_delay #(
      .payload_t (logic)
    ) i_switch_ack_delay (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .switch_n_i (domain_ctrl_o[d].switch_n),
      .ack_n_o    (switch_ack_n[d])
    );
  end

  // Memory bank switches share one cell model
  switch_ack_delay #(
    .payload_t (bank_mask_t)
  ) i_bank_switch_ack_delay (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (banks_switch_n_i),
    .ack_n_o    (banks_ack_n_o)
  );

  pwr_status_collector i_pwr_status_collector (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stat_i       (domain_stat),
    .intr_clear_i (intr_clear_i),
    .power_on_o   (power_on_o),
    .intr_o       (intr_o)
  );

endmodule

// ==== tb_power_harness.sv ====
/*
 * Power harness testbench
 * Drives power commands and bank switches, checks sequencing with assertions
 */
`timescale 1ns/1ps

module tb_power_harness
  import pwr_cfg_pkg::*;
  import pwr_types_pkg::*;
();

  localparam int CLK_HALF = 4;
  localparam int FULL_SEQ = 2 * (SWITCH_ACK_LATENCY + 6);
  localparam int NUM_CMDS = 4 * NUM_DOMAINS + 2;
  localparam int BANK_CYCLES = 4 * SWITCH_ACK_LATENCY;
  localparam int TRANSITION_TIMEOUT = FULL_SEQ;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * 2 * FULL_SEQ + BANK_CYCLES + 200;

  localparam domain_ctrl_t CTRL_ON  = '{switch_n: 1'b0, iso_n: 1'b1, rst_n: 1'b1};
  localparam domain_ctrl_t CTRL_OFF = '{switch_n: 1'b1, iso_n: 1'b0, rst_n: 1'b0};

  logic                           clk;
  logic                           rst_n;
  pwr_cmd_t                       cmd;
  logic         [NUM_DOMAINS-1:0] intr_clear;
  bank_mask_t                     banks_switch_n;
  domain_ctrl_t [NUM_DOMAINS-1:0] domain_ctrl;
  logic         [NUM_DOMAINS-1:0] power_on;
  logic         [NUM_DOMAINS-1:0] intr;
  bank_mask_t                     banks_ack_n;

  // Testbench bookkeeping
  logic [NUM_DOMAINS-1:0] busy;
  logic [NUM_DOMAINS-1:0] want_off;
  logic                   quiet;
  bank_mask_t             bank_hist [SWITCH_ACK_LATENCY];
  int                     run_cyc;
  int                     order [NUM_DOMAINS];
  integer                 seed = 32'h2f4a;
  int                     value_errs = 0;
  int                     other_errs = 0;

  power_harness_top i_power_harness_top (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .cmd_i            (cmd),
    .intr_clear_i     (intr_clear),
    .banks_switch_n_i (banks_switch_n),
    .domain_ctrl_o    (domain_ctrl),
    .power_on_o       (power_on),
    .intr_o           (intr),
    .banks_ack_n_o    (banks_ack_n)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    value_errs++;
    $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
  endtask

  task automatic order_error(input int d, input string what);
    other_errs++;
    $display("Domain %0d: %s", d, what);
  endtask

  task automatic print_counts();
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
  endtask

  function automatic logic [NUM_DOMAINS-1:0] domain_bit(input int d);
    logic [NUM_DOMAINS-1:0] m;
    m = '0;
    m[d] = 1'b1;
    return m;
  endfunction

  // Bank switch values as seen by the cell, one entry per cycle of latency
  always @(posedge clk) begin
    bank_hist[0] <= banks_switch_n;
    for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
      bank_hist[i] <= bank_hist[i-1];
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      run_cyc <= 0;
    end else begin
      run_cyc <= run_cyc + 1;
    end
  end

  assert property (@(posedge clk) $rose(rst_n) |-> power_on == '1)
    else value_error("power_on_o", 32'($sampled(power_on)), 32'('1));
  assert property (@(posedge clk) $rose(rst_n) |-> intr == '0)
    else value_error("intr_o", 32'($sampled(intr)), 32'h0);
  assert property (@(posedge clk) $rose(rst_n) |-> banks_ack_n == '0)
    else value_error("banks_ack_n_o", 32'($sampled(banks_ack_n)), 32'h0);

  assert property (@(posedge clk) disable iff (!rst_n)
    run_cyc >= SWITCH_ACK_LATENCY |-> banks_ack_n == bank_hist[SWITCH_ACK_LATENCY-1])
    else value_error("banks_ack_n_o", 32'($sampled(banks_ack_n)),
                     32'($sampled(bank_hist[SWITCH_ACK_LATENCY-1])));

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_check
    logic sw_prev;
    int   sw_age;

    // Cycles since the switch control last changed
    always @(posedge clk) begin
      if (domain_ctrl[d].switch_n != sw_prev) begin
        sw_age <= 1;
      end else if (sw_age < 1000) begin
        sw_age <= sw_age + 1;
      end
      sw_prev <= domain_ctrl[d].switch_n;
    end

    assert property (@(posedge clk) $rose(rst_n) |-> domain_ctrl[d] == CTRL_ON)
      else value_error($sformatf("domain_ctrl_o[%0d]", d),
                       32'($sampled(domain_ctrl[d])), 32'(CTRL_ON));

    // Power-off order
    assert property (@(posedge clk) disable iff (!rst_n)
      $fell(domain_ctrl[d].rst_n) |-> $past(!domain_ctrl[d].iso_n))
      else order_error(d, "reset asserted before isolation");
    assert property (@(posedge clk) disable iff (!rst_n)
      $rose(domain_ctrl[d].switch_n) |-> $past(!domain_ctrl[d].rst_n))
      else order_error(d, "switch opened before reset was asserted");
    assert property (@(posedge clk) disable iff (!rst_n)
      $fell(power_on[d]) |-> sw_age >= SWITCH_ACK_LATENCY)
      else order_error(d, "power dropped before the switch acknowledge latency");

    // Power-on order
    assert property (@(posedge clk) disable iff (!rst_n)
      $fell(domain_ctrl[d].switch_n) |-> !domain_ctrl[d].rst_n && !domain_ctrl[d].iso_n)
      else order_error(d, "switch closed while reset or isolation was released");
    assert property (@(posedge clk) disable iff (!rst_n)
      $rose(domain_ctrl[d].rst_n) |->
        !domain_ctrl[d].switch_n && sw_age >= SWITCH_ACK_LATENCY)
      else order_error(d, "reset released before the switch acknowledge latency");
    assert property (@(posedge clk) disable iff (!rst_n)
      $rose(domain_ctrl[d].iso_n) |-> $past(domain_ctrl[d].rst_n))
      else order_error(d, "isolation released before reset");
    assert property (@(posedge clk) disable iff (!rst_n)
      $rose(power_on[d]) |-> !domain_ctrl[d].switch_n)
      else order_error(d, "power reported on with the switch open");

    assert property (@(posedge clk) disable iff (!rst_n)
      $fell(intr[d]) |-> $past(intr_clear[d]))
      else order_error(d, "interrupt cleared without its clear bit");
    assert property (@(posedge clk) disable iff (!rst_n)
      !$stable(domain_ctrl[d]) |-> busy[d])
      else order_error(d, "controls changed without a command to this domain");

    // Settled state follows the last command
    assert property (@(posedge clk) disable iff (!rst_n)
      quiet |-> power_on[d] == !want_off[d])
      else value_error($sformatf("power_on_o[%0d]", d),
                       32'($sampled(power_on[d])), 32'(!$sampled(want_off[d])));
    assert property (@(posedge clk) disable iff (!rst_n)
      quiet |-> domain_ctrl[d] == (want_off[d] ? CTRL_OFF : CTRL_ON))
      else value_error($sformatf("domain_ctrl_o[%0d]", d), 32'($sampled(domain_ctrl[d])),
                       32'($sampled(want_off[d]) ? CTRL_OFF : CTRL_ON));
    assert property (@(posedge clk) disable iff (!rst_n)
      quiet |-> !intr[d])
      else value_error($sformatf("intr_o[%0d]", d), 32'($sampled(intr[d])), 32'h0);
  end

  task automatic send_cmd(input int d, input logic off);
    pwr_cmd_t c;
    c.valid  = 1'b1;
    c.domain = DOMAIN_IDX_W'(d);
    c.off    = off;
    @(posedge clk);
    cmd         <= c;
    busy[d]     <= 1'b1;
    want_off[d] <= off;
    @(posedge clk);
    cmd <= '0;
  endtask

  // Completion interrupt is the end of a transition
  task automatic wait_intr(input int d);
    int n;
    for (n = 0; n < TRANSITION_TIMEOUT; n++) begin
      @(negedge clk);
      if (intr[d]) begin
        break;
      end
    end
    if (!intr[d]) begin
      order_error(d, "no completion interrupt before the transition timeout");
    end
  endtask

  task automatic clear_intr(input logic [NUM_DOMAINS-1:0] mask);
    @(posedge clk);
    intr_clear <= mask;
    @(posedge clk);
    intr_clear <= '0;
  endtask

  task automatic settle_check();
    @(posedge clk);
    quiet <= 1'b1;
    @(posedge clk);
    quiet <= 1'b0;
  endtask

  task automatic run_transition(input int d, input logic off);
    send_cmd(d, off);
    wait_intr(d);
    clear_intr(domain_bit(d));
    busy[d] <= 1'b0;
    settle_check();
  endtask

  task automatic shuffle_order();
    int j;
    int t;
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      order[i] = i;
    end
    for (int i = NUM_DOMAINS - 1; i > 0; i--) begin
      j = int'($unsigned($random(seed)) % (i + 1));
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
  endtask

  // All domains switch together, then one interrupt is cleared alone
  task automatic run_all(input logic off);
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      send_cmd(d, off);
    end
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      wait_intr(d);
    end
    clear_intr(domain_bit(0));
    repeat (2) @(posedge clk);
    clear_intr(~domain_bit(0));
    busy <= '0;
    settle_check();
  endtask

  // Second command lands while the off sequence waits for the switch
  task automatic run_mid_sequence(input int d);
    send_cmd(d, 1'b1);
    repeat (4) @(posedge clk);
    send_cmd(d, 1'b0);
    wait_intr(d);
    clear_intr(domain_bit(d));
    wait_intr(d);
    clear_intr(domain_bit(d));
    busy[d] <= 1'b0;
    settle_check();
  endtask

  task automatic run_banks();
    for (int i = 0; i < BANK_CYCLES; i++) begin
      @(posedge clk);
      banks_switch_n <= bank_mask_t'($random(seed));
    end
    @(posedge clk);
    banks_switch_n <= '0;
    repeat (SWITCH_ACK_LATENCY + 2) @(posedge clk);
  endtask

  initial begin
    rst_n          <= 1'b0;
    cmd            <= '0;
    intr_clear     <= '0;
    banks_switch_n <= '0;
    busy           <= '0;
    want_off       <= '0;
    quiet          <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    shuffle_order();
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      run_transition(order[i], 1'b1);
    end
    shuffle_order();
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      run_transition(order[i], 1'b0);
    end

    run_mid_sequence(order[0]);
    run_all(1'b1);
    run_all(1'b0);
    run_banks();

    print_counts();
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    print_counts();
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
pwr_cfg_pkg.sv
pwr_types_pkg.sv
switch_ack_delay.sv
pwr_cmd_decoder.sv
pwr_domain_seq.sv
pwr_status_collector.sv
power_harness_top.sv
tb_power_harness.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the power harness testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert \
    --top-module tb_power_harness -f vlog.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_power_harness 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
